// ==== bench/core_ctrl_stimulus.txt ====
# op addr_or_keys data expected, hex; ky keys {cont1,cont2}, data = random pairs
# ky expect {rst,p2s,coin,fire,r,l,d,u}; px pins {vb,hb,vs,hs,b,g,r}, expect {de,vs,hs,rgb}
wr F2000000 0000000B 0
rd F2000000 00000000 0000000B
wr F1000000 00C3A55A 1
rd F1000000 00000000 00C3A55A
rd F0000000 00000000 00000001
wt 00000000 00000000 0
wr F0000000 00000001 1
rd F0000000 00000000 00000001
wt 00000000 00000000 0
rd F0000000 00000000 00000000
rd F8000000 00000000 00000000
rd F8001234 00000000 00000000
rd F3000000 00000000 00000000
ky 00000000 00000000 00
ky 00110000 00000000 11
ky 40000202 00000000 22
ky 02008008 00000000 48
ky 80000004 00000000 84
ky 00000080 00000020 10
ky 00000000 00000000 00
px 00 0 4000000
px 01 0 4FF0000
px 0B 0 5FFFF00
px 07 0 4FFFFFF
px 2A 0 100FF00
px 2C 0 10000FF
px 45 0 0FF00FF
px 56 0 200FFFF
px 60 0 0000000

// ==== flist.f ====
+incdir+hw
hw/core_ctrl_pkg.sv
hw/bridge_regs.sv
hw/reset_stretch.sv
hw/pad_merge.sv
hw/pixel_expand.sv
hw/core_ctrl_top.sv
bench/core_ctrl_tb.sv

// ==== bench/core_ctrl_tb.sv ====
////////////////////////////////////////
// testbench for the control top level
// stimulus file reader, merge reference,
// immediate checks and per-step reporting
////////////////////////////////////////

`include "core_ctrl_settings.svh"

module core_ctrl_tb import core_ctrl_pkg::*; ();

    // dut inputs
    logic                  clk_74a = 1'b0;
    logic                  temp_reset;
    bridge_word_t          bridge_addr;
    logic                  bridge_wr;
    bridge_word_t          bridge_wr_data;
    logic                  bridge_rd;
    key_map_t              cont1_key;
    key_map_t              cont2_key;
    logic                  game_red, game_green, game_blue;
    logic                  game_hs, game_vs, game_hblank, game_vblank;

    // dut outputs
    bridge_word_t          bridge_rd_data;
    dip_byte_t             dsw0, dsw1, dsw2;
    logic [`MODE_BITS-1:0] mode;
    logic                  game_reset;
    logic                  ctl_up, ctl_down, ctl_left, ctl_right;
    logic                  ctl_fire, ctl_coin, ctl_p2_start;
    rgb24_t                video_rgb;
    logic                  video_hs, video_vs, video_de;

    // run bookkeeping
    integer seed = 32'hea54;
    int     cycle_count = 0;
    int     cycle_limit = 2 * `RESET_HOLD_CYCLES + 16;
    int     strobe_cycle = 0;
    int     tests = 0;
    int     checks = 0;
    int     errors = 0;
    int     test_errors = 0;
    string  test_name = "reset";

    core_ctrl_top core_ctrl_top_inst (.*);

    always #4 clk_74a = ~clk_74a;

    // watchdog, the limit grows with every step read
    always @(posedge clk_74a) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no progress within %0d cycles at %s", cycle_limit, test_name);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // reference and checks

    // arcade controls from two key maps, {restart, p2s, coin, fire, r, l, d, u}
    function automatic logic [7:0] merge_rules(input key_map_t p1, input key_map_t p2);
        logic [7:0] ctl;
        ctl[0] = p1[`KEY_UP] | p2[`KEY_UP];
        ctl[1] = p1[`KEY_DOWN] | p2[`KEY_DOWN];
        ctl[2] = p1[`KEY_LEFT] | p2[`KEY_LEFT];
        ctl[3] = p1[`KEY_RIGHT] | p2[`KEY_RIGHT];
        ctl[4] = |{p1[`KEY_A], p1[`KEY_B], p1[`KEY_X], p1[`KEY_Y],
                   p2[`KEY_A], p2[`KEY_B], p2[`KEY_X], p2[`KEY_Y]};
        ctl[5] = p1[`KEY_SELECT] | p2[`KEY_SELECT];
        ctl[6] = p1[`KEY_R1] | p2[`KEY_START];
        ctl[7] = p1[`KEY_START];
        return ctl;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[FAIL] %s %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    ////////////////////////////////////////
    // step tasks, each ends at a falling edge

    task automatic bridge_write(input bridge_word_t addr, input bridge_word_t data,
                                input logic exp_reset);
        @(posedge clk_74a);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
        @(negedge clk_74a);
        // hold timing counted from the strobe edge
        if (addr == `ADDR_RESET_CMD || addr == `ADDR_DIP) begin
            strobe_cycle = cycle_count;
        end
        if (addr == `ADDR_DIP) begin
            check_value("dsw", data[3*`DIP_BITS-1:0], {dsw2, dsw1, dsw0});
        end
        if (addr == `ADDR_MODE) begin
            check_value("mode", data[`MODE_BITS-1:0], mode);
        end
        @(negedge clk_74a);
        check_value("game_reset", exp_reset, game_reset);
    endtask

    task automatic bridge_read(input bridge_word_t addr, input bridge_word_t expected);
        @(posedge clk_74a);
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        @(posedge clk_74a);
        bridge_rd <= 1'b0;
        @(negedge clk_74a);
        check_value("bridge_rd_data", expected, bridge_rd_data);
    endtask

    task automatic wait_hold_end();
        int elapsed;
        elapsed = cycle_count - strobe_cycle;
        while (game_reset === 1'b1 && elapsed < `RESET_HOLD_CYCLES + 4) begin
            @(negedge clk_74a);
            elapsed = cycle_count - strobe_cycle;
        end
        check_value("game_reset", 1'b0, game_reset);
        // full count must pass before the release
        assert (elapsed >= `RESET_HOLD_CYCLES) else begin
            $display("%s: game_reset dropped after only %0d cycles", test_name, elapsed);
            test_errors++;
        end
    endtask

    task automatic apply_keys(input key_map_t p1, input key_map_t p2, input logic [7:0] expected);
        @(posedge clk_74a);
        cont1_key <= p1;
        cont2_key <= p2;
        repeat (2) @(posedge clk_74a);
        @(negedge clk_74a);
        // game_reset stands in for restart, timer idle here
        check_value("controls", expected, {game_reset, ctl_p2_start, ctl_coin, ctl_fire,
                                           ctl_right, ctl_left, ctl_down, ctl_up});
    endtask

    // pins {vblank, hblank, vs, hs, b, g, r}, expected {de, vs, hs, rgb}
    task automatic apply_pixel(input logic [6:0] pins, input logic [26:0] expected);
        @(posedge clk_74a);
        game_red    <= pins[0];
        game_green  <= pins[1];
        game_blue   <= pins[2];
        game_hs     <= pins[3];
        game_vs     <= pins[4];
        game_hblank <= pins[5];
        game_vblank <= pins[6];
        repeat (2) @(posedge clk_74a);
        @(negedge clk_74a);
        check_value("video", expected, {video_de, video_vs, video_hs, video_rgb});
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        integer       fd;
        integer       code;
        int           line_no;
        logic [63:0]  op_word;
        logic [1023:0] skip_line;
        bridge_word_t arg;
        bridge_word_t data;
        bridge_word_t expected;
        key_map_t     p1;
        key_map_t     p2;
        line_no        = 0;
        temp_reset     = 1'b1;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        bridge_rd      = 1'b0;
        cont1_key      = '0;
        cont2_key      = '0;
        {game_red, game_green, game_blue, game_hs, game_vs} = '0;
        {game_hblank, game_vblank} = '0;
        repeat (3) @(posedge clk_74a);
        temp_reset <= 1'b0;
        @(negedge clk_74a);

        fd = $fopen("bench/core_ctrl_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/core_ctrl_stimulus.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            code = $fscanf(fd, "%s", op_word);
            if (code == 1 && op_word == "#") begin
                // column notes, rest of the line skipped
                code = $fgets(skip_line, fd);
            end else if (code == 1) begin
                code = $fscanf(fd, "%h %h %h", arg, data, expected);
                line_no++;
                test_name = $sformatf("step%0d", line_no);
                test_errors = 0;
                cycle_limit += 8;
                case (op_word)
                    "wr": bridge_write(arg, data, expected[0]);
                    "rd": bridge_read(arg, expected);
                    "wt": wait_hold_end();
                    "px": apply_pixel(arg[6:0], expected[26:0]);
                    "ky": begin
                        cycle_limit += 8 * data;
                        apply_keys(arg[31:16], arg[15:0], expected[7:0]);
                        // random pairs checked against the merge rules
                        repeat (data) begin
                            p1 = $random(seed);
                            p2 = $random(seed);
                            apply_keys(p1, p2, merge_rules(p1, p2));
                        end
                    end
                    default: begin
                        $display("%s: unknown operation in the stimulus file", test_name);
                        test_errors++;
                    end
                endcase
                tests++;
                errors += test_errors;
                $display("test %s done with %0d errors", test_name, test_errors);
            end
        end
        if (tests == 0) begin
            $display("no test steps were read from the stimulus file");
            errors++;
        end

        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== hw/core_ctrl_top.sv ====
////////////////////////////////////////
// control top level
// bridge registers, reset stretch,
// controller merge and pixel expansion
////////////////////////////////////////

`include "core_ctrl_settings.svh"

module core_ctrl_top import core_ctrl_pkg::*; (
    input  logic                  clk_74a,
    input  logic                  temp_reset,

    // bridge bus
    input  bridge_word_t          bridge_addr,
    input  logic                  bridge_wr,
    input  bridge_word_t          bridge_wr_data,
    input  logic                  bridge_rd,
    output bridge_word_t          bridge_rd_data,

    // controllers
    input  key_map_t              cont1_key,
    input  key_map_t              cont2_key,

    // video from the game
    input  logic                  game_red,
    input  logic                  game_green,
    input  logic                  game_blue,
    input  logic                  game_hs,
    input  logic                  game_vs,
    input  logic                  game_hblank,
    input  logic                  game_vblank,

    // settings and reset to the game
    output dip_byte_t             dsw0,
    output dip_byte_t             dsw1,
    output dip_byte_t             dsw2,
    output logic [`MODE_BITS-1:0] mode,
    output logic                  game_reset,

    // merged controls to the game
    output logic                  ctl_up,
    output logic                  ctl_down,
    output logic                  ctl_left,
    output logic                  ctl_right,
    output logic                  ctl_fire,
    output logic                  ctl_coin,
    output logic                  ctl_p2_start,

    // video to the scaler
    output rgb24_t                video_rgb,
    output logic                  video_hs,
    output logic                  video_vs,
    output logic                  video_de
);

    // bridge to timer
    logic reset_pulse;
    logic hold_active;
    // player 1 start to timer
    logic restart;

    ////////////////////////////////////////
    // bridge registers

    bridge_regs bridge_regs_inst (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .bridge_addr    (bridge_addr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_wr      (bridge_wr),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .hold_active    (hold_active),
        .reset_pulse    (reset_pulse),
        .dsw0           (dsw0),
        .dsw1           (dsw1),
        .dsw2           (dsw2),
        .mode           (mode)
    );

    ////////////////////////////////////////
    // game reset

    reset_stretch reset_stretch_inst (
        .clk_74a     (clk_74a),
        .temp_reset  (temp_reset),
        .reset_pulse (reset_pulse),
        .restart     (restart),
        .game_reset  (game_reset),
        .hold_active (hold_active)
    );

    ////////////////////////////////////////
    // controls and video

    pad_merge pad_merge_inst (
        .clk_74a      (clk_74a),
        .temp_reset   (temp_reset),
        .cont1_key    (cont1_key),
        .cont2_key    (cont2_key),
        .ctl_up       (ctl_up),
        .ctl_down     (ctl_down),
        .ctl_left     (ctl_left),
        .ctl_right    (ctl_right),
        .ctl_fire     (ctl_fire),
        .ctl_coin     (ctl_coin),
        .ctl_p2_start (ctl_p2_start),
        .restart      (restart)
    );

    pixel_expand pixel_expand_inst (
        .clk_74a     (clk_74a),
        .temp_reset  (temp_reset),
        .game_red    (game_red),
        .game_green  (game_green),
        .game_blue   (game_blue),
        .game_hs     (game_hs),
        .game_vs     (game_vs),
        .game_hblank (game_hblank),
        .game_vblank (game_vblank),
        .video_rgb   (video_rgb),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .video_de    (video_de)
    );

endmodule

// ==== hw/pixel_expand.sv ====
////////////////////////////////////////
// rgb111 to rgb24 expansion
// with data enable from the blanks
////////////////////////////////////////

`include "core_ctrl_settings.svh"

module pixel_expand import core_ctrl_pkg::*; (
    input  logic   clk_74a,
    input  logic   temp_reset,
    input  logic   game_red,
    input  logic   game_green,
    input  logic   game_blue,
    input  logic   game_hs,
    input  logic   game_vs,
    input  logic   game_hblank,
    input  logic   game_vblank,
    output rgb24_t video_rgb,
    output logic   video_hs,
    output logic   video_vs,
    output logic   video_de
);

    // each colour bit fills its whole field
    always_ff @(posedge clk_74a) begin
        video_rgb <= {{`COLOR_BITS{game_red}},
                      {`COLOR_BITS{game_green}},
                      {`COLOR_BITS{game_blue}}};
    end

    ////////////////////////////////////////
    // sync and enable, same stage as pixel

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            video_de <= 1'b0;
        end else begin
            video_hs <= game_hs;
            video_vs <= game_vs;
            // active only outside both blanks
            video_de <= ~(game_hblank | game_vblank);
        end
    end

endmodule

// ==== hw/pad_merge.sv ====
////////////////////////////////////////
// controller decode and merge
// two key bitmaps into one set of
// registered arcade controls
////////////////////////////////////////

`include "core_ctrl_settings.svh"

module pad_merge import core_ctrl_pkg::*; (
    input  logic     clk_74a,
    input  logic     temp_reset,
    input  key_map_t cont1_key,
    input  key_map_t cont2_key,
    output logic     ctl_up,
    output logic     ctl_down,
    output logic     ctl_left,
    output logic     ctl_right,
    output logic     ctl_fire,
    output logic     ctl_coin,
    output logic     ctl_p2_start,
    output logic     restart
);

    // any face button counts as fire
    function automatic logic key_fire(input key_map_t keys);
        return keys[`KEY_A] | keys[`KEY_B] | keys[`KEY_X] | keys[`KEY_Y];
    endfunction

    // merged controls before the output register
    logic m_up;
    logic m_down;
    logic m_left;
    logic m_right;
    logic m_fire;
    logic m_coin;
    logic m_p2_start;

    ////////////////////////////////////////
    // merge

    // directions shared by both players
    assign m_up    = cont1_key[`KEY_UP]    | cont2_key[`KEY_UP];
    assign m_down  = cont1_key[`KEY_DOWN]  | cont2_key[`KEY_DOWN];
    assign m_left  = cont1_key[`KEY_LEFT]  | cont2_key[`KEY_LEFT];
    assign m_right = cont1_key[`KEY_RIGHT] | cont2_key[`KEY_RIGHT];

    assign m_fire = key_fire(cont1_key) | key_fire(cont2_key);

    // either select inserts a coin
    assign m_coin = cont1_key[`KEY_SELECT] | cont2_key[`KEY_SELECT];

    // player 1 start is taken for restart,
    // so R1 on pad 1 doubles as 2P start
    assign m_p2_start = cont1_key[`KEY_R1] | cont2_key[`KEY_START];

    ////////////////////////////////////////
    // output register

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            ctl_up       <= 1'b0;
            ctl_down     <= 1'b0;
            ctl_left     <= 1'b0;
            ctl_right    <= 1'b0;
            ctl_fire     <= 1'b0;
            ctl_coin     <= 1'b0;
            ctl_p2_start <= 1'b0;
            restart      <= 1'b0;
        end else begin
            ctl_up       <= m_up;
            ctl_down     <= m_down;
            ctl_left     <= m_left;
            ctl_right    <= m_right;
            ctl_fire     <= m_fire;
            ctl_coin     <= m_coin;
            ctl_p2_start <= m_p2_start;
            restart      <= cont1_key[`KEY_START];
        end
    end

endmodule

// ==== hw/reset_stretch.sv ====
////////////////////////////////////////
// reset stretch timer
// holds the game in reset after a pulse,
// merged with the start-button restart
////////////////////////////////////////

`include "core_ctrl_settings.svh"

module reset_stretch import core_ctrl_pkg::*; (
    input  logic clk_74a,
    input  logic temp_reset,
    input  logic reset_pulse,
    input  logic restart,
    output logic game_reset,
    output logic hold_active
);

    // value loaded on every pulse
    localparam hold_count_t HOLD_LOAD = hold_count_t'(`RESET_HOLD_CYCLES);

    // remaining hold cycles, zero when idle
    hold_count_t hold_count;

    ////////////////////////////////////////
    // down-counter

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            hold_count <= '0;
        end else if (reset_pulse) begin
            // new pulse restarts the full hold
            hold_count <= HOLD_LOAD;
        end else if (hold_count != '0) begin
            hold_count <= hold_count - 1'b1;
        end
    end

    // high for exactly HOLD_LOAD cycles after the load
    assign hold_active = (hold_count != '0);

    // restart from player 1 start acts at once, no stretch
    assign game_reset = hold_active | restart;

    ////////////////////////////////////////
    // checks

    // count only ever loads or decrements
    a_count_bound : assert property (
        @(posedge clk_74a) disable iff (temp_reset)
        hold_count <= HOLD_LOAD
    ) else $error("hold counter above RESET_HOLD_CYCLES");

endmodule

// ==== hw/bridge_regs.sv ====
////////////////////////////////////////
// bridge register block
// reset command, dip bank and core mode,
// reset pulse and registered read-back
////////////////////////////////////////

`include "core_ctrl_settings.svh"

module bridge_regs import core_ctrl_pkg::*; (
    input  logic                  clk_74a,
    input  logic                  temp_reset,

    // bridge bus, single-cycle strobes
    input  bridge_word_t          bridge_addr,
    input  bridge_word_t          bridge_wr_data,
    input  logic                  bridge_wr,
    input  logic                  bridge_rd,
    output bridge_word_t          bridge_rd_data,

    // status from the reset stretch timer
    input  logic                  hold_active,
    output logic                  reset_pulse,

    // decoded settings to the game
    output dip_byte_t             dsw0,
    output dip_byte_t             dsw1,
    output dip_byte_t             dsw2,
    output logic [`MODE_BITS-1:0] mode
);

    // full words kept so read-back is exact
    bridge_word_t dip_word;
    bridge_word_t mode_word;

    // read mux output, sampled on bridge_rd
    bridge_word_t rd_word;

    // write decode
    logic wr_reset_cmd;
    logic wr_dip;
    logic wr_mode;

    ////////////////////////////////////////
    // write decode

    assign wr_reset_cmd = bridge_wr && (bridge_addr == `ADDR_RESET_CMD);
    assign wr_dip       = bridge_wr && (bridge_addr == `ADDR_DIP);
    assign wr_mode      = bridge_wr && (bridge_addr == `ADDR_MODE);

    ////////////////////////////////////////
    // read mux

    always_comb begin
        case (bridge_addr)
            // bit 0 is high while the game is held in reset
            `ADDR_RESET_CMD: rd_word = {{(`WORD_BITS-1){1'b0}}, hold_active};
            `ADDR_DIP:       rd_word = dip_word;
            `ADDR_MODE:      rd_word = mode_word;
            // unmapped, incl. the old command window
            default:         rd_word = '0;
        endcase
    end

    ////////////////////////////////////////
    // registers

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            reset_pulse    <= 1'b0;
            dip_word       <= '0;
            mode_word      <= '0;
            bridge_rd_data <= '0;
        end else begin
            // reset command and any dip change restart the game
            reset_pulse <= wr_reset_cmd | wr_dip;

            if (wr_dip) begin
                dip_word <= bridge_wr_data;
            end

            // mode change does not touch the game reset
            if (wr_mode) begin
                mode_word <= bridge_wr_data;
            end

            // read data held until the next read strobe
            if (bridge_rd) begin
                bridge_rd_data <= rd_word;
            end
        end
    end

    // dip banks from the low three bytes
    assign dsw0 = dip_word[`DIP_BITS-1:0];
    assign dsw1 = dip_word[2*`DIP_BITS-1:`DIP_BITS];
    assign dsw2 = dip_word[3*`DIP_BITS-1:2*`DIP_BITS];

    // mode from the low bits only
    assign mode = mode_word[`MODE_BITS-1:0];

    ////////////////////////////////////////
    // checks

    // writes come as isolated strobes, so the
    // pulse into the timer is always one cycle
    a_pulse_single : assert property (
        @(posedge clk_74a) disable iff (temp_reset)
        reset_pulse |=> !reset_pulse
    ) else $error("reset_pulse high for two consecutive cycles");

endmodule

// ==== hw/core_ctrl_pkg.sv ====
////////////////////////////////////////
// shared types for the control block
// bridge words, key bitmaps, dip bytes,
// pixels and the hold timer count
////////////////////////////////////////

`include "core_ctrl_settings.svh"

package core_ctrl_pkg;

    // bridge address or data word
    typedef logic [`WORD_BITS-1:0] bridge_word_t;

    // one controller, one bit per key
    // pressed key reads as 1
    typedef logic [`KEY_BITS-1:0] key_map_t;

    // one bank of eight dip switches
    typedef logic [`DIP_BITS-1:0] dip_byte_t;

    // pixel to the scaler, red in the top byte
    typedef logic [3*`COLOR_BITS-1:0] rgb24_t;

    // reset stretch down-counter
    typedef logic [`HOLD_BITS-1:0] hold_count_t;

endpackage

// ==== hw/core_ctrl_settings.svh ====
////////////////////////////////////////
// bridge register addresses, reset hold length,
// controller key bit positions and bus widths
////////////////////////////////////////

`ifndef CORE_CTRL_SETTINGS_SVH
`define CORE_CTRL_SETTINGS_SVH

// bridge register map
`define ADDR_RESET_CMD    32'hF000_0000
`define ADDR_DIP          32'hF100_0000
`define ADDR_MODE         32'hF200_0000

// game core held in reset this many cycles
`define RESET_HOLD_CYCLES 8000

// key bitmap positions, same on every controller
`define KEY_UP            0
`define KEY_DOWN          1
`define KEY_LEFT          2
`define KEY_RIGHT         3
`define KEY_A             4
`define KEY_B             5
`define KEY_X             6
`define KEY_Y             7
`define KEY_R1            9
`define KEY_SELECT        14
`define KEY_START         15

// widths
`define WORD_BITS         32
`define KEY_BITS          16
`define DIP_BITS          8
`define COLOR_BITS        8
`define HOLD_BITS         32
`define MODE_BITS         4

`endif
